// ==== Bender.yml ====
package:
  name: amber_sys

sources:
  - source/amber_sys_pkg.sv
  - source/wb_rr_arb2.sv
  - source/wb_slave_decode.sv
  - source/boot_mem.sv
  - source/timer_irq.sv
  - source/amber_sys.sv
  - target: test
    files:
      - tests/amber_sys_sva.sv
      - tests/tb_amber_sys.sv

// ==== sim.f ====
source/amber_sys_pkg.sv
source/wb_rr_arb2.sv
source/wb_slave_decode.sv
source/boot_mem.sv
source/timer_irq.sv
source/amber_sys.sv
tests/amber_sys_sva.sv
tests/tb_amber_sys.sv

// ==== source/amber_sys.sv ====
// Top level of the dual-master bus system
// Arbiter, slave decoder, boot memory and timer

`timescale 1ns/1ps
`default_nettype none

module amber_sys import amber_sys_pkg::*; #(
    parameter int BOOT_MEM_WORDS = 256
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    // Master A
    input  wire [WB_ADR_W-1:0]  i_a_adr,
    input  wire [WB_SEL_W-1:0]  i_a_sel,
    input  wire                 i_a_we,
    input  wire [WB_DAT_W-1:0]  i_a_dat,
    input  wire                 i_a_cyc,
    input  wire                 i_a_stb,
    output wire [WB_DAT_W-1:0]  o_a_dat,
    output wire                 o_a_ack,
    output wire                 o_a_err,

    // Master B
    input  wire [WB_ADR_W-1:0]  i_b_adr,
    input  wire [WB_SEL_W-1:0]  i_b_sel,
    input  wire                 i_b_we,
    input  wire [WB_DAT_W-1:0]  i_b_dat,
    input  wire                 i_b_cyc,
    input  wire                 i_b_stb,
    output wire [WB_DAT_W-1:0]  o_b_dat,
    output wire                 o_b_ack,
    output wire                 o_b_err,

    output wire                 o_irq
);

    // Merged bus
    wire [WB_ADR_W-1:0] m_adr;
    wire [WB_SEL_W-1:0] m_sel;
    wire                m_we;
    wire [WB_DAT_W-1:0] m_dat_w;
    wire [WB_DAT_W-1:0] m_dat_r;
    wire                m_cyc;
    wire                m_stb;
    wire                m_ack;
    wire                m_err;

    // Slave strobes and replies
    wire                mem_stb;
    wire [WB_DAT_W-1:0] mem_dat;
    wire                mem_ack;
    wire                tmr_stb;
    wire [WB_DAT_W-1:0] tmr_dat;
    wire                tmr_ack;

    // ----------------------------------------
    // Arbiter and decoder
    // ----------------------------------------
    wb_rr_arb2 u_wb_rr_arb2 (
        .i_clk   (i_clk),   .i_rst_n (i_rst_n),
        .i_a_adr (i_a_adr), .i_a_sel (i_a_sel), .i_a_we  (i_a_we),
        .i_a_dat (i_a_dat), .i_a_cyc (i_a_cyc), .i_a_stb (i_a_stb),
        .o_a_dat (o_a_dat), .o_a_ack (o_a_ack), .o_a_err (o_a_err),
        .i_b_adr (i_b_adr), .i_b_sel (i_b_sel), .i_b_we  (i_b_we),
        .i_b_dat (i_b_dat), .i_b_cyc (i_b_cyc), .i_b_stb (i_b_stb),
        .o_b_dat (o_b_dat), .o_b_ack (o_b_ack), .o_b_err (o_b_err),
        .o_m_adr (m_adr),   .o_m_sel (m_sel),   .o_m_we  (m_we),
        .o_m_dat (m_dat_w), .o_m_cyc (m_cyc),   .o_m_stb (m_stb),
        .i_m_dat (m_dat_r), .i_m_ack (m_ack),   .i_m_err (m_err)
    );

    wb_slave_decode u_wb_slave_decode (
        .i_clk     (i_clk),   .i_rst_n   (i_rst_n),
        .i_adr     (m_adr),   .i_cyc     (m_cyc),   .i_stb     (m_stb),
        .o_dat     (m_dat_r), .o_ack     (m_ack),   .o_err     (m_err),
        .o_mem_stb (mem_stb), .o_tmr_stb (tmr_stb),
        .i_mem_dat (mem_dat), .i_mem_ack (mem_ack),
        .i_tmr_dat (tmr_dat), .i_tmr_ack (tmr_ack)
    );

    // ----------------------------------------
    // Slaves
    // ----------------------------------------
    boot_mem #(
        .BOOT_MEM_WORDS (BOOT_MEM_WORDS)
    ) u_boot_mem (
        .i_clk (i_clk),   .i_adr (m_adr),   .i_sel (m_sel),
        .i_we  (m_we),    .i_dat (m_dat_w), .i_stb (mem_stb),
        .o_dat (mem_dat), .o_ack (mem_ack)
    );

    timer_irq u_timer_irq (
        .i_clk (i_clk),   .i_rst_n (i_rst_n), .i_adr (m_adr),
        .i_we  (m_we),    .i_dat   (m_dat_w), .i_stb (tmr_stb),
        .o_dat (tmr_dat), .o_ack   (tmr_ack), .o_irq (o_irq)
    );

endmodule

`default_nettype wire

// ==== source/amber_sys_pkg.sv ====
// Shared definitions for the dual-master bus system
// Wishbone widths, slave address map, slave select codes,
// timer register offsets and arbiter states

`default_nettype none

package amber_sys_pkg;

    // Bus widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // Address field that picks a slave
    localparam int SLV_SEL_MSB = 31;
    localparam int SLV_SEL_LSB = 28;

    typedef enum logic [3:0] {
        SLV_BOOT_MEM = 4'd0,
        SLV_TIMER    = 4'd1,
        SLV_NONE     = 4'hf
    } slave_sel_e;

    // Timer word offsets, address bits 4 down to 2
    typedef enum logic [2:0] {
        REG_LOAD   = 3'd0,
        REG_VALUE  = 3'd1,
        REG_CTRL   = 3'd2,
        REG_STATUS = 3'd3,
        REG_ENABLE = 3'd4,
        REG_CLEAR  = 3'd5
    } timer_reg_e;

    typedef enum logic [1:0] {
        ARB_IDLE    = 2'd0,
        ARB_GRANT_A = 2'd1,
        ARB_GRANT_B = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

// ==== source/boot_mem.sv ====
// Boot memory slave
// Word-addressed embedded RAM with byte-select writes
// and a registered acknowledge

`timescale 1ns/1ps
`default_nettype none

module boot_mem import amber_sys_pkg::*; #(
    parameter int BOOT_MEM_WORDS = 256
) (
    input  wire                 i_clk,
    input  wire [WB_ADR_W-1:0]  i_adr,
    input  wire [WB_SEL_W-1:0]  i_sel,
    input  wire                 i_we,
    input  wire [WB_DAT_W-1:0]  i_dat,
    input  wire                 i_stb,
    output logic [WB_DAT_W-1:0] o_dat,
    output logic                o_ack
);

    localparam int IDX_W = $clog2(BOOT_MEM_WORDS);

    logic [WB_DAT_W-1:0] mem [BOOT_MEM_WORDS];
    logic [WB_ADR_W-3:0] word_adr;
    logic [IDX_W-1:0]    mem_idx;
    logic                start;

    // Word index wraps at the memory depth
    assign word_adr = i_adr[WB_ADR_W-1:2];
    assign mem_idx  = IDX_W'(word_adr % BOOT_MEM_WORDS);

    // Accept once per strobe since stb stays high through the ack cycle
    assign start = i_stb & ~o_ack;

    always_ff @(posedge i_clk) begin
        if (start && i_we) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (i_sel[b]) begin
                    mem[mem_idx][8*b +: 8] <= i_dat[8*b +: 8];
                end
            end
        end
        if (start) begin
            o_dat <= mem[mem_idx];
        end
        o_ack <= start;
    end

endmodule

`default_nettype wire

// ==== source/timer_irq.sv ====
// Timer slave with interrupt register block
// Down counter with reload, pending status, interrupt enable
// and write-one-to-clear

`timescale 1ns/1ps
`default_nettype none

module timer_irq import amber_sys_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire [WB_ADR_W-1:0]  i_adr,
    input  wire                 i_we,
    input  wire [WB_DAT_W-1:0]  i_dat,
    input  wire                 i_stb,
    output logic [WB_DAT_W-1:0] o_dat,
    output logic                o_ack,
    output logic                o_irq
);

    timer_reg_e          reg_off;
    logic [WB_DAT_W-1:0] load_q;
    logic [WB_DAT_W-1:0] count_q;
    logic                run_q;
    logic                pend_q;
    logic                irq_en_q;
    logic                start;
    logic                wr;
    logic [WB_DAT_W-1:0] rd_word;

    assign reg_off = timer_reg_e'(i_adr[4:2]);
    assign start   = i_stb & ~o_ack;
    assign wr      = start & i_we;

    // ----------------------------------------
    // Counter and registers
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_q   <= '0;
            count_q  <= '0;
            run_q    <= 1'b0;
            pend_q   <= 1'b0;
            irq_en_q <= 1'b0;
            o_ack    <= 1'b0;
        end else begin
            o_ack <= start;
            if (wr && reg_off == REG_CLEAR && i_dat[0]) begin
                pend_q <= 1'b0;
            end
            // Reload on zero
            // An expiry in the clear cycle keeps the interrupt pending
            if (run_q) begin
                if (count_q == '0) begin
                    count_q <= load_q;
                    pend_q  <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
            if (wr) begin
                case (reg_off)
                    REG_LOAD: begin
                        load_q  <= i_dat;
                        count_q <= i_dat;
                    end
                    REG_CTRL:   run_q    <= i_dat[0];
                    REG_ENABLE: irq_en_q <= i_dat[0];
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        case (reg_off)
            REG_LOAD:   rd_word = load_q;
            REG_VALUE:  rd_word = count_q;
            REG_CTRL:   rd_word = {{(WB_DAT_W-1){1'b0}}, run_q};
            REG_STATUS: rd_word = {{(WB_DAT_W-1){1'b0}}, pend_q};
            REG_ENABLE: rd_word = {{(WB_DAT_W-1){1'b0}}, irq_en_q};
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            o_dat <= rd_word;
        end
    end

    assign o_irq = pend_q & irq_en_q;

endmodule

`default_nettype wire

// ==== source/wb_rr_arb2.sv ====
// Two-master round-robin Wishbone arbiter
// Grant FSM with last-granted flag, request steering onto the
// merged port and reply routing back to the owner

`timescale 1ns/1ps
`default_nettype none

module wb_rr_arb2 import amber_sys_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    // Master A
    input  wire [WB_ADR_W-1:0]  i_a_adr,
    input  wire [WB_SEL_W-1:0]  i_a_sel,
    input  wire                 i_a_we,
    input  wire [WB_DAT_W-1:0]  i_a_dat,
    input  wire                 i_a_cyc,
    input  wire                 i_a_stb,
    output logic [WB_DAT_W-1:0] o_a_dat,
    output logic                o_a_ack,
    output logic                o_a_err,

    // Master B
    input  wire [WB_ADR_W-1:0]  i_b_adr,
    input  wire [WB_SEL_W-1:0]  i_b_sel,
    input  wire                 i_b_we,
    input  wire [WB_DAT_W-1:0]  i_b_dat,
    input  wire                 i_b_cyc,
    input  wire                 i_b_stb,
    output logic [WB_DAT_W-1:0] o_b_dat,
    output logic                o_b_ack,
    output logic                o_b_err,

    // Merged port
    output logic [WB_ADR_W-1:0] o_m_adr,
    output logic [WB_SEL_W-1:0] o_m_sel,
    output logic                o_m_we,
    output logic [WB_DAT_W-1:0] o_m_dat,
    output logic                o_m_cyc,
    output logic                o_m_stb,
    input  wire [WB_DAT_W-1:0]  i_m_dat,
    input  wire                 i_m_ack,
    input  wire                 i_m_err
);

    arb_state_e state;
    logic       last_b;
    logic       a_req;
    logic       b_req;
    logic       grant_a;
    logic       grant_b;

    assign a_req = i_a_cyc & i_a_stb;
    assign b_req = i_b_cyc & i_b_stb;

    // ----------------------------------------
    // Grant FSM
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ARB_IDLE;
            // A wins the first tie
            last_b <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (a_req && (!b_req || last_b)) begin
                        state  <= ARB_GRANT_A;
                        last_b <= 1'b0;
                    end else if (b_req) begin
                        state  <= ARB_GRANT_B;
                        last_b <= 1'b1;
                    end
                end
                ARB_GRANT_A,
                ARB_GRANT_B: begin
                    if (i_m_ack || i_m_err) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign grant_a = (state == ARB_GRANT_A);
    assign grant_b = (state == ARB_GRANT_B);

    // ----------------------------------------
    // Request steering and reply routing
    // ----------------------------------------
    assign o_m_adr = grant_b ? i_b_adr : i_a_adr;
    assign o_m_sel = grant_b ? i_b_sel : i_a_sel;
    assign o_m_we  = grant_b ? i_b_we  : i_a_we;
    assign o_m_dat = grant_b ? i_b_dat : i_a_dat;
    // No cycle on the merged port while idle
    assign o_m_cyc = (grant_a & i_a_cyc) | (grant_b & i_b_cyc);
    assign o_m_stb = (grant_a & i_a_stb) | (grant_b & i_b_stb);

    assign o_a_dat = grant_a ? i_m_dat : '0;
    assign o_a_ack = grant_a & i_m_ack;
    assign o_a_err = grant_a & i_m_err;
    assign o_b_dat = grant_b ? i_m_dat : '0;
    assign o_b_ack = grant_b & i_m_ack;
    assign o_b_err = grant_b & i_m_err;

endmodule

`default_nettype wire

// ==== source/wb_slave_decode.sv ====
// Slave address decoder for the merged Wishbone bus
// Strobe steering, reply combiner and the error responder
// for unmapped addresses

`timescale 1ns/1ps
`default_nettype none

module wb_slave_decode import amber_sys_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    // Merged bus from the arbiter
    input  wire [WB_ADR_W-1:0]  i_adr,
    input  wire                 i_cyc,
    input  wire                 i_stb,
    output logic [WB_DAT_W-1:0] o_dat,
    output logic                o_ack,
    output logic                o_err,

    // Slave strobes
    output logic                o_mem_stb,
    output logic                o_tmr_stb,

    // Slave replies
    input  wire [WB_DAT_W-1:0]  i_mem_dat,
    input  wire                 i_mem_ack,
    input  wire [WB_DAT_W-1:0]  i_tmr_dat,
    input  wire                 i_tmr_ack
);

    slave_sel_e slv_sel;
    logic       access;
    logic       err_q;

    // Upper address nibble picks the slave
    always_comb begin
        case (i_adr[SLV_SEL_MSB:SLV_SEL_LSB])
            SLV_BOOT_MEM: slv_sel = SLV_BOOT_MEM;
            SLV_TIMER:    slv_sel = SLV_TIMER;
            default:      slv_sel = SLV_NONE;
        endcase
    end

    assign access    = i_cyc & i_stb;
    assign o_mem_stb = access & (slv_sel == SLV_BOOT_MEM);
    assign o_tmr_stb = access & (slv_sel == SLV_TIMER);

    // Error responder pulses once per unmapped access
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= access & (slv_sel == SLV_NONE) & ~err_q;
        end
    end

    // Only the acknowledging slave drives read data
    assign o_dat = ({WB_DAT_W{i_mem_ack}} & i_mem_dat)
                 | ({WB_DAT_W{i_tmr_ack}} & i_tmr_dat);
    assign o_ack = i_mem_ack | i_tmr_ack;
    assign o_err = err_q;

endmodule

`default_nettype wire

// ==== tests/amber_sys_sva.sv ====
// Assertions bound into the round-robin arbiter
// Ack and err exclusivity, merged strobe framing and
// ack only while the owning master strobes

`timescale 1ns/1ps
`default_nettype none

module amber_sys_sva (
    input wire i_clk,
    input wire i_rst_n,
    input wire i_a_stb,
    input wire i_b_stb,
    input wire o_a_ack,
    input wire o_a_err,
    input wire o_b_ack,
    input wire o_b_err,
    input wire o_m_cyc,
    input wire o_m_stb,
    input wire i_m_ack,
    input wire i_m_err
);

    // Ack and err are exclusive at every port
    ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_a_ack && o_a_err) && !(o_b_ack && o_b_err) && !(i_m_ack && i_m_err))
        else begin
            $error("ack and err high together");
            tb_amber_sys.assert_errs++;
        end

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_m_stb |-> o_m_cyc)
        else begin
            $error("merged stb high without cyc");
            tb_amber_sys.assert_errs++;
        end

    // A master only sees ack for its own strobe
    a_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_a_ack |-> i_a_stb)
        else begin
            $error("master A ack without stb");
            tb_amber_sys.assert_errs++;
        end

    b_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_b_ack |-> i_b_stb)
        else begin
            $error("master B ack without stb");
            tb_amber_sys.assert_errs++;
        end

endmodule

`default_nettype wire

// ==== tests/tb_amber_sys.sv ====
// Testbench for the dual-master bus system
// Clock and reset, one driver task per master, boot memory
// reference model, read compare process and directed tests

`timescale 1ns/1ps
`default_nettype none

module tb_amber_sys;

    localparam int          WAIT_CYC = 40;
    localparam logic [31:0] TMR_BASE = 32'h1000_0000;

    logic        clk;
    logic        rst_n;
    logic [31:0] a_adr;
    logic [3:0]  a_sel;
    logic        a_we;
    logic [31:0] a_dat;
    logic        a_cyc;
    logic        a_stb;
    logic [31:0] b_adr;
    logic [3:0]  b_sel;
    logic        b_we;
    logic [31:0] b_dat;
    logic        b_cyc;
    logic        b_stb;
    wire  [31:0] a_rdat;
    wire         a_ack;
    wire         a_err;
    wire  [31:0] b_rdat;
    wire         b_ack;
    wire         b_err;
    wire         irq;

    logic [31:0] ref_mem [256];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       name_q [$];
    int          seed = 32'h5239f3f0;
    int          checks;
    int          errors;
    int          timeouts;
    int          assert_errs;
    time         a_done_t;
    time         b_done_t;

    amber_sys #(
        .BOOT_MEM_WORDS (256)
    ) u_amber_sys (
        .i_clk   (clk),    .i_rst_n (rst_n),
        .i_a_adr (a_adr),  .i_a_sel (a_sel),  .i_a_we  (a_we),
        .i_a_dat (a_dat),  .i_a_cyc (a_cyc),  .i_a_stb (a_stb),
        .o_a_dat (a_rdat), .o_a_ack (a_ack),  .o_a_err (a_err),
        .i_b_adr (b_adr),  .i_b_sel (b_sel),  .i_b_we  (b_we),
        .i_b_dat (b_dat),  .i_b_cyc (b_cyc),  .i_b_stb (b_stb),
        .o_b_dat (b_rdat), .o_b_ack (b_ack),  .o_b_err (b_err),
        .o_irq   (irq)
    );

    bind wb_rr_arb2 amber_sys_sva u_arb_sva (.*);

    always #10 clk = ~clk;

    // ----------------------------------------
    // Reference model and bookkeeping
    // ----------------------------------------
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Memory writes update the model and memory reads queue a compare
    task automatic close_xfer(input string name, input string mst, input logic [31:0] adr,
                              input logic [3:0] sel, input logic we, input logic [31:0] wdat,
                              input logic [31:0] rdat, input logic ack, input logic err);
        int idx;
        idx = adr[9:2];
        if (!ack && !err) begin
            $display("ERROR: %s, master %s saw no ack or err within %0d cycles",
                     name, mst, WAIT_CYC);
            timeouts++;
        end else if (err && adr[31:28] < 4'h2) begin
            $display("FAIL %s: expected ack, actual err on master %s", name, mst);
            errors++;
        end else if (ack && adr[31:28] == 4'h0 && we) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], wdat, sel);
        end else if (ack && adr[31:28] == 4'h0) begin
            exp_q.push_back(ref_mem[idx]);
            act_q.push_back(rdat);
            name_q.push_back(name);
        end
    endtask

    // ----------------------------------------
    // Master drivers
    // ----------------------------------------
    task automatic a_transfer(input string name, input logic [31:0] adr, input logic [3:0] sel,
                              input logic we, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic ack, output logic err);
        int n;
        @(posedge clk);
        #1;
        a_adr = adr;
        a_sel = sel;
        a_we  = we;
        a_dat = wdat;
        a_cyc = 1'b1;
        a_stb = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!a_ack && !a_err && n < WAIT_CYC);
        rdat     = a_rdat;
        ack      = a_ack;
        err      = a_err;
        a_done_t = $time;
        close_xfer(name, "A", adr, sel, we, wdat, rdat, ack, err);
        @(posedge clk);
        #1;
        a_cyc = 1'b0;
        a_stb = 1'b0;
        a_we  = 1'b0;
    endtask

    task automatic b_transfer(input string name, input logic [31:0] adr, input logic [3:0] sel,
                              input logic we, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic ack, output logic err);
        int n;
        @(posedge clk);
        #1;
        b_adr = adr;
        b_sel = sel;
        b_we  = we;
        b_dat = wdat;
        b_cyc = 1'b1;
        b_stb = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!b_ack && !b_err && n < WAIT_CYC);
        rdat     = b_rdat;
        ack      = b_ack;
        err      = b_err;
        b_done_t = $time;
        close_xfer(name, "B", adr, sel, we, wdat, rdat, ack, err);
        @(posedge clk);
        #1;
        b_cyc = 1'b0;
        b_stb = 1'b0;
        b_we  = 1'b0;
    endtask

    // Read compare against the model
    always @(negedge clk) begin
        logic [31:0] exp_w;
        logic [31:0] act_w;
        string       name;
        while (act_q.size() > 0) begin
            exp_w = exp_q.pop_front();
            act_w = act_q.pop_front();
            name  = name_q.pop_front();
            if (act_w !== exp_w) begin
                $display("FAIL %s: expected %h, actual %h", name, exp_w, act_w);
                errors++;
            end
            checks++;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] wd;
        logic        ack;
        logic        ack2;
        logic        err;
        logic        err2;
        int          n;
        clk   = 1'b0;
        rst_n = 1'b0;
        a_adr = '0;
        a_sel = '0;
        a_we  = 1'b0;
        a_dat = '0;
        a_cyc = 1'b0;
        a_stb = 1'b0;
        b_adr = '0;
        b_sel = '0;
        b_we  = 1'b0;
        b_dat = '0;
        b_cyc = 1'b0;
        b_stb = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Full-word writes and reads on master A
        for (int i = 0; i < 8; i++) begin
            wd = $random(seed);
            a_transfer("full_write", 32'(i * 4), 4'hf, 1'b1, wd, rd, ack, err);
        end
        for (int i = 0; i < 8; i++) begin
            a_transfer("full_read", 32'(i * 4), 4'hf, 1'b0, '0, rd, ack, err);
        end

        // Partial byte writes on master B into the same words
        for (int i = 0; i < 8; i++) begin
            wd = $random(seed);
            b_transfer("byte_write", 32'(i * 4), 4'(i + 1), 1'b1, wd, rd, ack, err);
        end
        for (int i = 0; i < 8; i++) begin
            b_transfer("byte_read", 32'(i * 4), 4'hf, 1'b0, '0, rd, ack, err);
        end

        // B was granted last so A wins the same-cycle tie
        wd = $random(seed);
        fork
            a_transfer("tie_write_a", 32'h40, 4'hf, 1'b1, wd, rd, ack, err);
            b_transfer("tie_read_b", 32'h08, 4'hf, 1'b0, '0, rd2, ack2, err2);
        join
        if (a_done_t >= b_done_t) begin
            $display("FAIL tie_order: expected A ack before B, actual A at %0t, B at %0t",
                     a_done_t, b_done_t);
            errors++;
        end
        checks++;
        a_transfer("tie_read_a", 32'h40, 4'hf, 1'b0, '0, rd, ack, err);

        // Unmapped slave field
        a_transfer("unmapped", 32'h2000_0000, 4'hf, 1'b0, '0, rd, ack, err);
        if (!err || ack) begin
            $display("FAIL unmapped: expected err=1 ack=0, actual err=%0b ack=%0b", err, ack);
            errors++;
        end
        checks++;
        a_transfer("after_err", 32'h0, 4'hf, 1'b0, '0, rd, ack, err);
        if (!ack) begin
            $display("FAIL after_err: expected ack=1, actual ack=%0b", ack);
            errors++;
        end
        checks++;
        b_transfer("unmapped_b", 32'h3000_0000, 4'hf, 1'b0, '0, rd, ack, err);
        if (!err || ack) begin
            $display("FAIL unmapped_b: expected err=1 ack=0, actual err=%0b ack=%0b", err, ack);
            errors++;
        end
        checks++;

        // Timer interrupt
        a_transfer("tmr_load", TMR_BASE + 32'h00, 4'hf, 1'b1, 32'd20, rd, ack, err);
        a_transfer("tmr_enable", TMR_BASE + 32'h10, 4'hf, 1'b1, 32'd1, rd, ack, err);
        a_transfer("tmr_start", TMR_BASE + 32'h08, 4'hf, 1'b1, 32'd1, rd, ack, err);
        n = 0;
        while (!irq && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("ERROR: timer interrupt did not rise within 100 cycles");
            timeouts++;
        end
        a_transfer("tmr_status_set", TMR_BASE + 32'h0c, 4'hf, 1'b0, '0, rd, ack, err);
        if (rd !== 32'd1) begin
            $display("FAIL tmr_status_set: expected %h, actual %h", 32'd1, rd);
            errors++;
        end
        checks++;
        a_transfer("tmr_stop", TMR_BASE + 32'h08, 4'hf, 1'b1, 32'd0, rd, ack, err);
        a_transfer("tmr_clear", TMR_BASE + 32'h14, 4'hf, 1'b1, 32'd1, rd, ack, err);
        n = 0;
        while (irq && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (irq) begin
            $display("ERROR: timer interrupt stayed high after the clear");
            timeouts++;
        end
        a_transfer("tmr_status_clr", TMR_BASE + 32'h0c, 4'hf, 1'b0, '0, rd, ack, err);
        if (rd !== 32'd0) begin
            $display("FAIL tmr_status_clr: expected %h, actual %h", 32'd0, rd);
            errors++;
        end
        checks++;

        n = 0;
        while (act_q.size() > 0 && n < WAIT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (act_q.size() > 0) begin
            $display("ERROR: read compares still pending at the end of the run");
            timeouts++;
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, assert_errs);
        if (errors == 0 && timeouts == 0 && assert_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
